//--- source/camera_pkg.sv
// camera geometry package
// sizes of the VGA luminance plane delivered by the sensor and of the
// blocks that the frame is reduced to
package camera_pkg;

    // one sensor byte
    localparam int PIXEL_BITS = 8;

    // luminance plane of one VGA frame
    localparam int ACTIVE_SAMPLES = 640;
    localparam int ACTIVE_LINES   = 480;

    // block grid of 16 blocks across and 16 block rows down
    localparam int BLOCK_COLS  = 16;
    localparam int BLOCK_WIDTH = 40;
    localparam int BLOCK_LINES = 30;

    // 1200 samples of 8 bits fit easily in 20 bits
    localparam int SUM_BITS = 20;

    // block byte is sum[17:10] or roughly sum / 1024
    localparam int AVG_LSB = 10;

    // block column number
    typedef logic [3:0] block_index_t;

endpackage

//--- source/frame_pkg.sv
// frame buffer layout package
// a decimated frame is 16 block rows of 16 bytes each; the same 2048 bits
// are seen either as rows (for shifting in) or as one flat word (for the
// serial readout)
package frame_pkg;

    localparam int FRAME_ROWS = 16;
    localparam int FRAME_BITS = 2048;
    localparam int ROW_BITS   = 128;

    // one block row, block 0 in the lowest byte
    typedef logic [ROW_BITS-1:0] row_t;

    // row 15 is the newest row and sits in the highest bits,
    // so the flat view reads out the last block row first
    typedef union packed {
        logic [FRAME_BITS-1:0] bits;
        row_t [FRAME_ROWS-1:0] rows;
    } frame_t;

endpackage

//--- source/camera_capture.sv
// camera capture sequencer
// follows vsync and href of the sensor, keeps every other byte of a line
// (the Y byte comes first) and tags each sample with its block column;
// pulses block_row_end after every 30th line and raises frame_done once
// the last block row has been flushed
module camera_capture
    import camera_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  vsync,
    input  logic                  href,
    input  logic [PIXEL_BITS-1:0] pix_data,
    output logic                  sample_valid,
    output logic [PIXEL_BITS-1:0] sample_data,
    output block_index_t          block_col,
    output logic                  block_row_end,
    output logic                  frame_done
);

    typedef enum logic [3:0] {
        S_VS_HIGH,
        S_VS_LOW,
        S_WAIT_FIRST,
        S_READ,
        S_LINE_END,
        S_WAIT_HREF,
        S_ROW_FLUSH,
        S_LAST_FLUSH,
        S_DONE
    } state_t;

    typedef logic [$clog2(ACTIVE_SAMPLES+1)-1:0] sample_count_t;
    typedef logic [$clog2(BLOCK_WIDTH)-1:0]      block_phase_t;
    typedef logic [$clog2(ACTIVE_LINES+1)-1:0]   line_count_t;
    typedef logic [$clog2(BLOCK_LINES)-1:0]      block_line_t;

    state_t        state;
    state_t        next_state;
    logic          in_line;
    logic          take_y;
    logic          chroma_next;
    sample_count_t sample_count;
    block_phase_t  block_phase;
    block_index_t  col_count;
    line_count_t   line_count;
    block_line_t   block_line;

    always_comb begin
        next_state = state;
        case (state)
            S_VS_HIGH:    if (vsync) next_state = S_VS_LOW;
            S_VS_LOW:     if (!vsync) next_state = S_WAIT_FIRST;
            S_WAIT_FIRST: if (href) next_state = S_READ;
            S_READ:       if (!href) next_state = S_LINE_END;
            S_LINE_END: begin
                // line_count already holds the finished line
                if (line_count == line_count_t'(ACTIVE_LINES))
                    next_state = S_LAST_FLUSH;
                else if (block_line == '0)
                    next_state = S_ROW_FLUSH;
                else
                    next_state = S_WAIT_HREF;
            end
            S_WAIT_HREF:  if (href) next_state = S_READ;
            S_ROW_FLUSH:  next_state = S_WAIT_HREF;
            S_LAST_FLUSH: next_state = S_DONE;
            S_DONE:       next_state = S_DONE;
            default:      next_state = S_VS_HIGH;
        endcase
    end

    // bytes are taken in any state between lines too, so a short href gap
    // never loses the first byte of a line
    assign in_line = (state == S_WAIT_FIRST) || (state == S_READ) ||
                     (state == S_LINE_END) || (state == S_WAIT_HREF) ||
                     (state == S_ROW_FLUSH);
    assign take_y = in_line && href && !chroma_next &&
                    (sample_count < sample_count_t'(ACTIVE_SAMPLES));
    assign block_row_end = (state == S_ROW_FLUSH) || (state == S_LAST_FLUSH);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= S_VS_HIGH;
            line_count <= '0;
            block_line <= '0;
            frame_done <= 1'b0;
        end else begin
            state <= next_state;
            // one cycle late so the frame buffer has taken the last row
            frame_done <= (state == S_DONE);
            if (state == S_VS_HIGH || state == S_VS_LOW || state == S_WAIT_FIRST) begin
                line_count <= '0;
                block_line <= '0;
            end else if (state == S_READ && !href) begin
                line_count <= line_count + 1'b1;
                if (block_line == block_line_t'(BLOCK_LINES - 1))
                    block_line <= '0;
                else
                    block_line <= block_line + 1'b1;
            end
        end
    end

    // Y/chroma toggle and position within the line
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sample_valid <= 1'b0;
            chroma_next  <= 1'b0;
            sample_count <= '0;
            block_phase  <= '0;
            col_count    <= '0;
        end else begin
            sample_valid <= take_y;
            if (!(in_line && href)) begin
                chroma_next  <= 1'b0;
                sample_count <= '0;
                block_phase  <= '0;
                col_count    <= '0;
            end else begin
                chroma_next <= ~chroma_next;
                if (take_y) begin
                    sample_count <= sample_count + 1'b1;
                    if (block_phase == block_phase_t'(BLOCK_WIDTH - 1)) begin
                        block_phase <= '0;
                        col_count   <= col_count + 1'b1;
                    end else begin
                        block_phase <= block_phase + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_y) begin
            sample_data <= pix_data;
            block_col   <= col_count;
        end
    end

endmodule

//--- source/block_accumulators.sv
// block accumulators
// sums the luminance samples of each of the 16 blocks in the current
// block row; on block_row_end the scaled bytes are latched as one row,
// row_valid pulses and every sum starts again from zero
module block_accumulators
    import camera_pkg::*;
    import frame_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  sample_valid,
    input  logic [PIXEL_BITS-1:0] sample_data,
    input  block_index_t          block_col,
    input  logic                  block_row_end,
    output row_t                  row_bytes,
    output logic                  row_valid
);

    logic [SUM_BITS-1:0] sums [BLOCK_COLS];
    logic [SUM_BITS-1:0] sample_ext;

    assign sample_ext = {{(SUM_BITS - PIXEL_BITS){1'b0}}, sample_data};

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            row_valid <= 1'b0;
            for (int i = 0; i < BLOCK_COLS; i++)
                sums[i] <= '0;
        end else begin
            row_valid <= block_row_end;
            for (int i = 0; i < BLOCK_COLS; i++) begin
                if (block_row_end)
                    sums[i] <= (sample_valid && block_col == block_index_t'(i)) ?
                               sample_ext : '0;
                else if (sample_valid && block_col == block_index_t'(i))
                    sums[i] <= sums[i] + sample_ext;
            end
        end
    end

    // bits above the slice are dropped, so a bright block wraps
    always_ff @(posedge clk) begin
        if (block_row_end) begin
            for (int i = 0; i < BLOCK_COLS; i++)
                row_bytes[i*PIXEL_BITS +: PIXEL_BITS] <= sums[i][AVG_LSB +: PIXEL_BITS];
        end
    end

endmodule

//--- source/frame_buffer.sv
// decimated frame buffer
// a shift register of 16 block rows; each new row enters at the top
// (row 15) and the oldest row falls out of row 0
module frame_buffer
    import frame_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   row_valid,
    input  row_t   row_bytes,
    output frame_t frame
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            frame <= '0;
        end else if (row_valid) begin
            // every row moves one place down
            frame.rows <= {row_bytes, frame.rows[FRAME_ROWS-1:1]};
        end
    end

endmodule

//--- source/spi_readout.sv
// SPI slave for the frame readout
// sck is brought into the clk domain through two flops and its edges are
// detected there; the frame is captured when done rises and shifted out
// msb first, while sdi bits fill the register from the bottom
module spi_readout
    import frame_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   done,
    input  frame_t frame,
    input  logic   sck,
    input  logic   sdi,
    output logic   sdo
);

    logic                  sck_meta;
    logic                  sck_sync;
    logic                  sck_prev;
    logic                  sck_rise;
    logic                  sck_fall;
    logic                  done_prev;
    logic                  sdi_hold;
    logic [FRAME_BITS-1:0] shift_reg;

    assign sck_rise = sck_sync & ~sck_prev;
    assign sck_fall = ~sck_sync & sck_prev;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sck_meta  <= 1'b0;
            sck_sync  <= 1'b0;
            sck_prev  <= 1'b0;
            done_prev <= 1'b0;
            sdi_hold  <= 1'b0;
            shift_reg <= '0;
        end else begin
            sck_meta  <= sck;
            sck_sync  <= sck_meta;
            sck_prev  <= sck_sync;
            done_prev <= done;
            // master drives sdi for its rising edge
            if (sck_rise)
                sdi_hold <= sdi;
            if (done && !done_prev)
                shift_reg <= frame.bits;
            else if (sck_fall && done_prev)
                shift_reg <= {shift_reg[FRAME_BITS-2:0], sdi_hold};
        end
    end

    assign sdo = shift_reg[FRAME_BITS-1];

endmodule

//--- source/camera_frame_top.sv
// camera frame top level
// sensor capture, block averaging, frame buffer and SPI readout of the
// 16 by 16 decimated luminance frame
module camera_frame_top
    import camera_pkg::*;
    import frame_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  vsync,
    input  logic                  href,
    input  logic [PIXEL_BITS-1:0] pix_data,
    input  logic                  sck,
    input  logic                  sdi,
    output logic                  sdo,
    output logic                  done
);

    logic                  sample_valid;
    logic [PIXEL_BITS-1:0] sample_data;
    block_index_t          block_col;
    logic                  block_row_end;
    row_t                  row_bytes;
    logic                  row_valid;
    frame_t                frame;

    camera_capture u_capture (
        .clk           (clk),
        .reset         (reset),
        .vsync         (vsync),
        .href          (href),
        .pix_data      (pix_data),
        .sample_valid  (sample_valid),
        .sample_data   (sample_data),
        .block_col     (block_col),
        .block_row_end (block_row_end),
        .frame_done    (done)
    );

    block_accumulators u_accumulators (
        .clk           (clk),
        .reset         (reset),
        .sample_valid  (sample_valid),
        .sample_data   (sample_data),
        .block_col     (block_col),
        .block_row_end (block_row_end),
        .row_bytes     (row_bytes),
        .row_valid     (row_valid)
    );

    frame_buffer u_frame_buffer (
        .clk       (clk),
        .reset     (reset),
        .row_valid (row_valid),
        .row_bytes (row_bytes),
        .frame     (frame)
    );

    spi_readout u_spi (
        .clk   (clk),
        .reset (reset),
        .done  (done),
        .frame (frame),
        .sck   (sck),
        .sdi   (sdi),
        .sdo   (sdo)
    );

endmodule

//--- verif/camera_frame_checker.sv
// camera frame port checker
// concurrent assertions on done and sdo of the top level, bound to the DUT
module camera_frame_checker (
    input logic clk,
    input logic reset,
    input logic done,
    input logic sdo
);

    timeunit 1ns;
    timeprecision 100ps;

    // number of failed port assertions
    int fail_count = 0;

    // done is a sticky level once the frame is complete
    done_sticky: assert property (@(posedge clk) disable iff (reset)
        !$fell(done))
    else begin
        $error("done fell after it had risen");
        fail_count++;
    end

    sdo_idle: assert property (@(posedge clk) disable iff (reset)
        !done |-> !sdo)
    else begin
        $error("sdo went high before the frame was done");
        fail_count++;
    end

    done_reset: assert property (@(posedge clk)
        reset |=> !done)
    else begin
        $error("done was not low one clock after reset");
        fail_count++;
    end

    sdo_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(sdo))
    else begin
        $error("sdo is unknown after reset");
        fail_count++;
    end

endmodule

//--- verif/camera_frame_tb.sv
// camera frame testbench
// sends one random VGA frame as Y/chroma byte pairs, reads the decimated
// frame back over SPI and compares it with a block-sum model, then reads
// back the sdi bits shifted in during the first readout
module camera_frame_tb
    import camera_pkg::*;
    import frame_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int SCK_HALF  = 5;
    localparam int MAX_GAP   = 9;
    localparam int DONE_WAIT = 20;
    localparam int FRAME_CYCLES = 16 + 10 + ACTIVE_LINES * (2 * ACTIVE_SAMPLES + MAX_GAP)
                                  + DONE_WAIT + 4;
    localparam int READ_CYCLES  = 2 * FRAME_BITS * 2 * SCK_HALF;
    localparam int TIMEOUT_CYCLES = (FRAME_CYCLES + READ_CYCLES) * 12 / 10;

    logic                  clk;
    logic                  reset;
    logic                  vsync;
    logic                  href;
    logic [PIXEL_BITS-1:0] pix_data;
    logic                  sck;
    logic                  sdi;
    logic                  sdo;
    logic                  done;

    int                    seed = 32'h6d1e;
    int                    cycles = 0;
    int                    errors = 0;
    int                    passed = 0;
    int                    failed = 0;
    int                    readout_errors;
    logic [SUM_BITS-1:0]   y_sums [FRAME_ROWS][BLOCK_COLS];
    logic [SUM_BITS-1:0]   c_sums [FRAME_ROWS][BLOCK_COLS];
    logic [FRAME_BITS-1:0] exp_frame;
    logic [FRAME_BITS-1:0] chroma_frame;
    logic [FRAME_BITS-1:0] sent_bits;
    logic                  got;

    camera_frame_top DUT (
        .clk      (clk),
        .reset    (reset),
        .vsync    (vsync),
        .href     (href),
        .pix_data (pix_data),
        .sck      (sck),
        .sdi      (sdi),
        .sdo      (sdo),
        .done     (done)
    );

    bind camera_frame_top camera_frame_checker u_checker (
        .clk   (clk),
        .reset (reset),
        .done  (done),
        .sdo   (sdo)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the run did not finish", cycles);
            $display("Test failed");
            $finish;
        end
    end

    task automatic end_test(input string name);
        if (errors == 0) begin
            passed++;
            $display("%s: pass", name);
        end else begin
            failed++;
            $display("%s: FAIL with %0d errors", name, errors);
        end
        errors = 0;
    endtask

    // one frame of Y/chroma pairs with the model following every byte
    task automatic send_frame();
        int rnd;
        int gap;
        logic [PIXEL_BITS-1:0] y;
        logic [PIXEL_BITS-1:0] uv;
        vsync = 1'b1;
        repeat (4) @(negedge clk);
        vsync = 1'b0;
        repeat (6) @(negedge clk);
        for (int line = 0; line < ACTIVE_LINES; line++) begin
            href = 1'b1;
            for (int s = 0; s < ACTIVE_SAMPLES; s++) begin
                rnd = $random(seed);
                y = rnd[7:0];
                rnd = $random(seed);
                uv = rnd[7:0];
                y_sums[line / BLOCK_LINES][s / BLOCK_WIDTH] += {12'd0, y};
                c_sums[line / BLOCK_LINES][s / BLOCK_WIDTH] += {12'd0, uv};
                pix_data = y;
                @(negedge clk);
                pix_data = uv;
                @(negedge clk);
            end
            href = 1'b0;
            if (line < ACTIVE_LINES - 1) begin
                assert (done == 1'b0) else begin
                    $display("Mismatch at %0t: done high after line %0d", $time, line);
                    errors++;
                end
            end
            rnd = $random(seed);
            gap = 2 + (rnd & 7);
            repeat (gap) @(negedge clk);
        end
    endtask

    // one sck period with sdo taken as sck rises
    task automatic sck_period(input logic bit_in, output logic bit_out);
        sdi = bit_in;
        sck = 1'b1;
        bit_out = sdo;
        repeat (SCK_HALF) @(negedge clk);
        sck = 1'b0;
        repeat (SCK_HALF) @(negedge clk);
    endtask

    initial begin
        int rnd;
        int wait_count;
        reset = 1'b1;
        vsync = 1'b0;
        href = 1'b0;
        pix_data = '0;
        sck = 1'b0;
        sdi = 1'b0;
        for (int r = 0; r < FRAME_ROWS; r++) begin
            for (int c = 0; c < BLOCK_COLS; c++) begin
                y_sums[r][c] = '0;
                c_sums[r][c] = '0;
            end
        end
        repeat (16) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        assert (done == 1'b0 && sdo == 1'b0) else begin
            $display("Mismatch at %0t: done=%b sdo=%b after reset", $time, done, sdo);
            errors++;
        end
        send_frame();
        end_test("reset and idle until last line");

        wait_count = 0;
        while (!done && wait_count < DONE_WAIT) begin
            @(negedge clk);
            wait_count++;
        end
        assert (done) else begin
            $display("done did not rise after the full frame was sent");
            errors++;
        end
        end_test("done after frame");

        // row r column c sits at byte 16*r + c of the flat frame
        for (int r = 0; r < FRAME_ROWS; r++) begin
            for (int c = 0; c < BLOCK_COLS; c++) begin
                exp_frame[r * ROW_BITS + c * PIXEL_BITS +: PIXEL_BITS] =
                    y_sums[r][c][AVG_LSB +: PIXEL_BITS];
                chroma_frame[r * ROW_BITS + c * PIXEL_BITS +: PIXEL_BITS] =
                    c_sums[r][c][AVG_LSB +: PIXEL_BITS];
            end
        end
        repeat (4) @(negedge clk);
        for (int k = 0; k < FRAME_BITS; k++) begin
            rnd = $random(seed);
            sent_bits[k] = rnd[0];
            sck_period(rnd[0], got);
            assert (got === exp_frame[FRAME_BITS - 1 - k]) else begin
                $display("Mismatch at %0t: frame bit %0d read %b, expected %b",
                         $time, FRAME_BITS - 1 - k, got, exp_frame[FRAME_BITS - 1 - k]);
                errors++;
            end
        end
        readout_errors = errors;
        end_test("frame readout");

        assert (chroma_frame != exp_frame) else begin
            $display("chroma stimulus gives the same frame as luminance");
            errors++;
        end
        assert (readout_errors == 0) else begin
            $display("frame readout failed, so chroma rejection is not shown");
            errors++;
        end
        end_test("chroma ignored");

        for (int k = 0; k < FRAME_BITS; k++) begin
            sck_period(1'b0, got);
            assert (got === sent_bits[k]) else begin
                $display("Mismatch at %0t: echo bit %0d read %b, expected %b",
                         $time, k, got, sent_bits[k]);
                errors++;
            end
        end
        end_test("sdi echo");

        assert (DUT.u_checker.fail_count == 0) else begin
            $display("bound port assertions failed %0d times", DUT.u_checker.fail_count);
            errors++;
        end
        end_test("port assertions");

        $display("%0d tests passed, %0d tests failed", passed, failed);
        if (failed == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

//--- camera_frame.f
source/camera_pkg.sv
source/frame_pkg.sv
source/camera_capture.sv
source/block_accumulators.sv
source/frame_buffer.sv
source/spi_readout.sv
source/camera_frame_top.sv
verif/camera_frame_checker.sv
verif/camera_frame_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := camera_frame_tb
FILELIST  := camera_frame.f
OBJ_DIR   := obj_dir

SOURCES := $(shell cat $(FILELIST))
BINARY  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BINARY)
	@out="$$($(BINARY))"; echo "$$out"; \
	echo "$$out" | grep -q '^Test completed successfully$$'

clean:
	rm -rf $(OBJ_DIR)
